//--- Bender.yml
package:
  name: mac_pipeline

dependencies: {}

sources:
  # package first, stages before the top level
  - mac_pkg.sv
  - operand_mult_stage.sv
  - accumulator.sv
  - requant_stage.sv
  - mac_pipeline_top.sv

  # testbench
  - target: simulation
    files:
      - tb_mac_pipeline.sv

//--- accumulator.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sequential signed accumulator
// clear priority over valid, modulo wrap, registered overflow pulse
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module accumulator #(
    parameter int IN_WIDTH    = 2 * mac_pkg::IN_WIDTH_DEF, // product width from upstream
    parameter int ACCUM_WIDTH = mac_pkg::ACCUM_WIDTH_DEF   // sum width, wraps
) (
    input  logic                          clk_i,
    input  logic                          rst_i,      // sync, active high
    input  logic                          en_i,       // global pipeline enable
    input  logic                          clear_i,    // zero the sum, drop this beat
    input  logic                          valid_i,    // data_i carries a product
    input  logic signed [IN_WIDTH-1:0]    data_i,
    output logic signed [ACCUM_WIDTH-1:0] accum_o,    // running sum
    output logic                          overflow_o, // signed wrap on the last add
    output logic                          valid_o     // one pulse per accepted add
);

    logic signed [ACCUM_WIDTH-1:0] accum_reg;  // the sum itself
    logic signed [ACCUM_WIDTH-1:0] accum_next;
    logic signed [ACCUM_WIDTH-1:0] data_ext;   // sign-extended product
    logic signed [ACCUM_WIDTH-1:0] accum_sum;  // old sum plus data, wraps
    logic                          add_fire;   // valid beat that is not a clear
    logic                          overflow_d;
    logic                          overflow_reg;
    logic                          valid_reg;

    assign data_ext  = data_i;               // signed to wider signed, sign-extends
    assign accum_sum = accum_reg + data_ext; // carry out of the msb is dropped
    assign add_fire  = valid_i && !clear_i;

    // next sum, clear wins over valid
    always_comb begin
        if (clear_i) begin
            accum_next = '0;
        end else if (valid_i) begin
            accum_next = accum_sum;
        end else begin
            accum_next = accum_reg; // idle beat
        end
    end

    // overflow: same-sign addends, result sign flipped
    assign overflow_d = add_fire
        && (accum_reg[ACCUM_WIDTH-1] == data_ext[ACCUM_WIDTH-1])
        && (accum_sum[ACCUM_WIDTH-1] != accum_reg[ACCUM_WIDTH-1]);

    // every register loads on enabled edges only
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            accum_reg    <= '0;
            overflow_reg <= 1'b0;
            valid_reg    <= 1'b0;
        end else if (en_i) begin
            accum_reg    <= accum_next;
            overflow_reg <= overflow_d; // travels with the valid pulse
            valid_reg    <= add_fire;
        end
    end

    assign accum_o    = accum_reg;
    assign overflow_o = overflow_reg;
    assign valid_o    = valid_reg;

endmodule

//--- all.f
mac_pkg.sv
operand_mult_stage.sv
accumulator.sv
requant_stage.sv
mac_pipeline_top.sv
tb_mac_pipeline.sv

//--- mac_pipeline_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MAC pipeline top level
// multiply -> accumulate -> requantize, three enabled edges
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mac_pipeline_top #(
    parameter int IN_WIDTH    = mac_pkg::IN_WIDTH_DEF,    // operand width
    parameter int ACCUM_WIDTH = mac_pkg::ACCUM_WIDTH_DEF, // sum width
    parameter int OUT_WIDTH   = mac_pkg::OUT_WIDTH_DEF    // output width
) (
    input  logic                              clk_i,
    input  logic                              rst_i,      // sync, active high
    input  logic                              en_i,       // freezes every stage when low
    input  logic                              valid_i,
    input  logic                              clear_i,    // in order with the data
    input  logic signed [IN_WIDTH-1:0]        a_i,
    input  logic signed [IN_WIDTH-1:0]        b_i,
    input  logic [mac_pkg::SHIFT_WIDTH-1:0]   shift_i,
    input  mac_pkg::rnd_mode_e                rnd_mode_i,
    output logic signed [OUT_WIDTH-1:0]       result_o,
    output logic signed [ACCUM_WIDTH-1:0]     accum_o,    // raw wrapping sum
    output logic                              sat_o,
    output logic                              overflow_o,
    output logic                              valid_o
);

    localparam int PROD_WIDTH = 2 * IN_WIDTH; // product handed to the accumulator

    // stage 1 -> stage 2
    logic signed [PROD_WIDTH-1:0]  prod;
    logic                          prod_valid;
    logic                          prod_clear;

    // stage 2 -> stage 3
    logic signed [ACCUM_WIDTH-1:0] accum;
    logic                          accum_valid;
    logic                          accum_overflow;

    operand_mult_stage #(
        .IN_WIDTH     (IN_WIDTH)
    ) mult_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .en_i         (en_i),
        .valid_i      (valid_i),
        .clear_i      (clear_i),
        .a_i          (a_i),
        .b_i          (b_i),
        .prod_o       (prod),
        .prod_valid_o (prod_valid),
        .prod_clear_o (prod_clear)
    );

    // accumulator input is the full product width
    accumulator #(
        .IN_WIDTH    (PROD_WIDTH),
        .ACCUM_WIDTH (ACCUM_WIDTH)
    ) accum_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .en_i        (en_i),
        .clear_i     (prod_clear),
        .valid_i     (prod_valid),
        .data_i      (prod),
        .accum_o     (accum),
        .overflow_o  (accum_overflow),
        .valid_o     (accum_valid)
    );

    requant_stage #(
        .ACCUM_WIDTH (ACCUM_WIDTH),
        .OUT_WIDTH   (OUT_WIDTH)
    ) requant_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .en_i        (en_i),
        .valid_i     (accum_valid),
        .overflow_i  (accum_overflow),
        .accum_i     (accum),
        .shift_i     (shift_i),
        .rnd_mode_i  (rnd_mode_i),
        .result_o    (result_o),
        .accum_o     (accum_o),    // registered copy, aligned with valid_o
        .sat_o       (sat_o),
        .overflow_o  (overflow_o),
        .valid_o     (valid_o)
    );

endmodule

//--- mac_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths for the MAC pipeline
// runtime shift-amount width
// rounding-mode opcode for the requantize stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mac_pkg;

    // default datapath widths, overridden from the top level
    parameter int IN_WIDTH_DEF    = 8;  // signed operand width
    parameter int ACCUM_WIDTH_DEF = 32; // wrapping accumulator width
    parameter int OUT_WIDTH_DEF   = 8;  // requantized output width

    // shift_i range is 0 .. 2**SHIFT_WIDTH-1
    parameter int SHIFT_WIDTH = 5;

    // rounding applied before the arithmetic right shift
    typedef enum logic {
        RND_TRUNC   = 1'b0, // drop shifted-out bits, rounds toward -inf
        RND_HALF_UP = 1'b1  // add half an output lsb first
    } rnd_mode_e;

endpackage

//--- operand_mult_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// operand/multiply stage of the MAC pipeline
// full-width signed product, registered with valid and clear
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module operand_mult_stage #(
    parameter int IN_WIDTH = mac_pkg::IN_WIDTH_DEF // operand width
) (
    input  logic                        clk_i,
    input  logic                        rst_i,        // sync, active high
    input  logic                        en_i,         // global pipeline enable
    input  logic                        valid_i,      // operand beat valid
    input  logic                        clear_i,      // restart the sum at this beat
    input  logic signed [IN_WIDTH-1:0]  a_i,
    input  logic signed [IN_WIDTH-1:0]  b_i,
    output logic signed [2*IN_WIDTH-1:0] prod_o,      // registered product
    output logic                        prod_valid_o,
    output logic                        prod_clear_o
);

    localparam int PROD_WIDTH = 2 * IN_WIDTH; // no bits lost in the product

    logic signed [PROD_WIDTH-1:0] prod_d; // combinational product

    // both operands signed, so the multiply is signed at full width
    assign prod_d = a_i * b_i;

    // strobes, cleared by reset
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            prod_valid_o <= 1'b0;
            prod_clear_o <= 1'b0;
        end else if (en_i) begin
            prod_valid_o <= valid_i; // clear priority is resolved downstream
            prod_clear_o <= clear_i;
        end
    end

    // product payload
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            prod_o <= prod_d; // loads even on idle beats, valid qualifies it
        end
    end

endmodule

//--- requant_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// requantize stage: round, arithmetic shift right, saturate
// raw sum and overflow registered alongside the result
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module requant_stage #(
    parameter int ACCUM_WIDTH = mac_pkg::ACCUM_WIDTH_DEF, // incoming sum width
    parameter int OUT_WIDTH   = mac_pkg::OUT_WIDTH_DEF    // narrow output width
) (
    input  logic                              clk_i,
    input  logic                              rst_i,      // sync, active high
    input  logic                              en_i,       // global pipeline enable
    input  logic                              valid_i,    // sum updated by a valid add
    input  logic                              overflow_i, // wrap flag from the accumulator
    input  logic signed [ACCUM_WIDTH-1:0]     accum_i,
    input  logic [mac_pkg::SHIFT_WIDTH-1:0]   shift_i,    // quasi-static
    input  mac_pkg::rnd_mode_e                rnd_mode_i, // quasi-static
    output logic signed [OUT_WIDTH-1:0]       result_o,   // meaningful with valid_o
    output logic signed [ACCUM_WIDTH-1:0]     accum_o,    // raw sum, aligned with result_o
    output logic                              sat_o,      // result_o was clipped
    output logic                              overflow_o,
    output logic                              valid_o
);

    import mac_pkg::*;

    // wide enough for the sum and for the largest rounding constant,
    // plus one bit so the rounding add never wraps
    localparam int RND_WIDTH =
        ((ACCUM_WIDTH > (1 << SHIFT_WIDTH)) ? ACCUM_WIDTH : (1 << SHIFT_WIDTH)) + 1;
    localparam int HI_WIDTH = RND_WIDTH - OUT_WIDTH + 1; // bits that must agree to fit

    localparam logic signed [OUT_WIDTH-1:0] OUT_MAX = {1'b0, {(OUT_WIDTH-1){1'b1}}};
    localparam logic signed [OUT_WIDTH-1:0] OUT_MIN = {1'b1, {(OUT_WIDTH-1){1'b0}}};

    logic signed [RND_WIDTH-1:0] sum_ext;  // sign-extended sum
    logic signed [RND_WIDTH-1:0] rnd_add;  // half an output lsb, or zero
    logic signed [RND_WIDTH-1:0] rounded;
    logic signed [RND_WIDTH-1:0] shifted;
    logic        [HI_WIDTH-1:0]  hi_bits;  // sign bit of the output and everything above
    logic                        fits;
    logic signed [OUT_WIDTH-1:0] result_d;
    logic                        sat_d;

    assign sum_ext = accum_i;

    // 2**(shift-1), only for half-up with a nonzero shift
    always_comb begin
        rnd_add = '0;
        if (rnd_mode_i == RND_HALF_UP && shift_i != '0) begin
            rnd_add = {{(RND_WIDTH-1){1'b0}}, 1'b1} << (shift_i - SHIFT_WIDTH'(1));
        end
    end

    assign rounded = sum_ext + rnd_add;
    assign shifted = rounded >>> shift_i; // arithmetic, rounded is signed

    // in range when all upper bits equal the output sign bit
    assign hi_bits = shifted[RND_WIDTH-1:OUT_WIDTH-1];
    assign fits    = (&hi_bits) || !(|hi_bits);

    always_comb begin
        if (fits) begin
            result_d = shifted[OUT_WIDTH-1:0];
            sat_d    = 1'b0;
        end else begin
            result_d = shifted[RND_WIDTH-1] ? OUT_MIN : OUT_MAX; // clip toward the sign
            sat_d    = 1'b1;
        end
    end

    // output registers, enabled edges only
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            result_o   <= '0;
            accum_o    <= '0;
            sat_o      <= 1'b0;
            overflow_o <= 1'b0;
            valid_o    <= 1'b0;
        end else if (en_i) begin
            result_o   <= result_d;
            accum_o    <= accum_i;    // raw sum, same edge as the result
            sat_o      <= sat_d;
            overflow_o <= overflow_i;
            valid_o    <= valid_i;
        end
    end

endmodule

//--- tb_mac_pipeline.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the MAC pipeline top level
// LFSR stimulus, three-entry reference model, output checks
// watchdog against a hung run
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_mac_pipeline;

    import mac_pkg::*;

    localparam int IN_W       = 8;
    localparam int AW         = 20;  // small sum, overflow within a short run
    localparam int OW         = 8;
    localparam int CLK_PERIOD = 4;
    localparam int GAP        = 4;   // idle enabled beats between phases
    localparam int PH_RAND    = 300;
    localparam int PH_OVF     = 150;
    localparam int PH_REQ     = 60;
    localparam int N_REQ      = 8;   // requantize sub-phases
    localparam int N_CYCLES   = 2 * PH_RAND + 2 * PH_OVF + N_REQ * PH_REQ + 16 * GAP + 32;
    localparam int TIMEOUT    = N_CYCLES * CLK_PERIOD * 2 + 400;
    localparam int STYLE_RAND = 0;   // any operands
    localparam int STYLE_POS  = 1;   // large positive products
    localparam int STYLE_NEG  = 2;   // large negative products

    localparam longint ACC_MAX = (longint'(1) <<< (AW - 1)) - 1;
    localparam longint ACC_MIN = -(longint'(1) <<< (AW - 1));
    localparam longint OUT_MAX = (longint'(1) <<< (OW - 1)) - 1;
    localparam longint OUT_MIN = -(longint'(1) <<< (OW - 1));

    logic                   clk_i;
    logic                   rst_i;
    logic                   en_i;
    logic                   valid_i;
    logic                   clear_i;
    logic signed [IN_W-1:0] a_i;
    logic signed [IN_W-1:0] b_i;
    logic [SHIFT_WIDTH-1:0] shift_i;
    rnd_mode_e              rnd_mode_i;
    logic signed [OW-1:0]   result_o;
    logic signed [AW-1:0]   accum_o;
    logic                   sat_o;
    logic                   overflow_o;
    logic                   valid_o;

    // reference model state
    logic signed [AW-1:0]   model_sum;
    logic                   pipe_valid [3];
    logic                   pipe_ovf [3];
    logic signed [AW-1:0]   pipe_sum [3];
    logic                   exp_valid;       // entry that left on the last enabled edge
    logic                   exp_ovf;
    logic signed [AW-1:0]   exp_accum;
    logic signed [OW-1:0]   exp_result;
    logic                   exp_sat;

    logic [31:0]            lfsr_state;
    logic [SHIFT_WIDTH-1:0] cur_shift;
    rnd_mode_e              cur_rnd;
    int                     n_checks;
    int                     mismatch_cnt;
    int                     other_cnt;
    int                     valid_seen;
    int                     ovf_seen;
    int                     sat_seen;

    mac_pipeline_top #(
        .IN_WIDTH    (IN_W),
        .ACCUM_WIDTH (AW),
        .OUT_WIDTH   (OW)
    ) dut_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .en_i        (en_i),
        .valid_i     (valid_i),
        .clear_i     (clear_i),
        .a_i         (a_i),
        .b_i         (b_i),
        .shift_i     (shift_i),
        .rnd_mode_i  (rnd_mode_i),
        .result_o    (result_o),
        .accum_o     (accum_o),
        .sat_o       (sat_o),
        .overflow_o  (overflow_o),
        .valid_o     (valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] v);
        int k;
        v = '0;
        for (k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // round half up if asked, arithmetic shift, clip to the output range
    task automatic requant_model(input logic signed [AW-1:0] sum,
                                 input logic [SHIFT_WIDTH-1:0] sh,
                                 input rnd_mode_e mode,
                                 output logic signed [OW-1:0] res,
                                 output logic sat);
        longint v;
        v = longint'(sum);
        if (mode == RND_HALF_UP && sh != 0) begin
            v = v + (longint'(1) <<< (sh - 1));
        end
        v = v >>> sh;
        sat = 1'b1;
        if (v > OUT_MAX) begin
            res = OUT_MAX[OW-1:0];
        end else if (v < OUT_MIN) begin
            res = OUT_MIN[OW-1:0];
        end else begin
            res = v[OW-1:0];
            sat = 1'b0;
        end
    endtask

    // called at an enabled edge with the beat the DUT just sampled
    task automatic model_step();
        longint prod;
        longint full;
        logic   nv;
        logic   novf;
        prod = longint'(a_i) * longint'(b_i);
        nv   = 1'b0;
        novf = 1'b0;
        if (clear_i) begin
            model_sum = '0;             // clear wins, product dropped
        end else if (valid_i) begin
            full      = longint'(model_sum) + prod;
            novf      = (full > ACC_MAX) || (full < ACC_MIN);
            model_sum = full[AW-1:0];   // wraps modulo 2**AW
            nv        = 1'b1;
        end
        pipe_valid[2] = pipe_valid[1];
        pipe_ovf[2]   = pipe_ovf[1];
        pipe_sum[2]   = pipe_sum[1];
        pipe_valid[1] = pipe_valid[0];
        pipe_ovf[1]   = pipe_ovf[0];
        pipe_sum[1]   = pipe_sum[0];
        pipe_valid[0] = nv;
        pipe_ovf[0]   = novf;
        pipe_sum[0]   = model_sum;
        exp_valid = pipe_valid[2];      // third enabled edge, leaves now
        exp_ovf   = pipe_ovf[2];
        exp_accum = pipe_sum[2];
        requant_model(pipe_sum[2], shift_i, rnd_mode_i, exp_result, exp_sat);
    endtask

    task automatic check_outputs();
        n_checks++;
        if (valid_o !== exp_valid) begin
            mismatch_cnt++;
            $display("mismatch at %0t: valid_o %b, expected %b", $time, valid_o, exp_valid);
        end
        if (overflow_o !== exp_ovf) begin
            mismatch_cnt++;
            $display("mismatch at %0t: overflow_o %b, expected %b", $time, overflow_o, exp_ovf);
        end
        if (accum_o !== exp_accum) begin
            mismatch_cnt++;
            $display("mismatch at %0t: accum_o %0d, expected %0d", $time, accum_o, exp_accum);
        end
        if (exp_valid) begin
            if (result_o !== exp_result) begin
                mismatch_cnt++;
                $display("mismatch at %0t: result_o %0d, expected %0d (shift %0d, mode %s)",
                         $time, result_o, exp_result, shift_i, rnd_mode_i.name());
            end
            if (sat_o !== exp_sat) begin
                mismatch_cnt++;
                $display("mismatch at %0t: sat_o %b, expected %b", $time, sat_o, exp_sat);
            end
        end
    endtask

    // one clock: model update on enabled edges, new inputs, check at the falling edge
    task automatic drive_cycle(input logic en, input logic vld, input logic clr,
                               input logic signed [IN_W-1:0] a,
                               input logic signed [IN_W-1:0] b);
        @(posedge clk_i);
        if (en_i) begin
            model_step();
            if (exp_valid) valid_seen++;
            if (exp_valid && exp_ovf) ovf_seen++;
            if (exp_valid && exp_sat) sat_seen++;
        end
        en_i       <= en;
        valid_i    <= vld;
        clear_i    <= clr;
        a_i        <= a;
        b_i        <= b;
        shift_i    <= cur_shift;
        rnd_mode_i <= cur_rnd;
        @(negedge clk_i);
        check_outputs();    // also catches outputs moving during stalls
    endtask

    task automatic idle_gap();
        int k;
        for (k = 0; k < GAP; k++) begin
            drive_cycle(1'b1, 1'b0, 1'b0, '0, '0);
        end
    endtask

    task automatic run_phase(input int n, input logic stall, input logic clr_on,
                             input int style);
        int                     k;
        logic [31:0]            r;
        logic                   en;
        logic                   vld;
        logic                   clr;
        logic signed [IN_W-1:0] a;
        logic signed [IN_W-1:0] b;
        for (k = 0; k < n; k++) begin
            draw_bits(IN_W, r);
            a = r[IN_W-1:0];
            draw_bits(IN_W, r);
            b = r[IN_W-1:0];
            if (style == STYLE_POS) begin
                a[IN_W-1:IN_W-2] = 2'b01;   // 64 .. 127
                b[IN_W-1:IN_W-2] = 2'b01;
            end else if (style == STYLE_NEG) begin
                a[IN_W-1:IN_W-2] = 2'b01;
                b[IN_W-1:IN_W-2] = 2'b10;   // -128 .. -65
            end
            draw_bits(2, r);
            vld = (r[1:0] != 2'b00);        // about 3 in 4
            clr = 1'b0;
            if (clr_on) begin
                draw_bits(5, r);
                clr = (r[4:0] == 5'd0);     // rare
            end
            en = 1'b1;
            if (stall) begin
                draw_bits(5, r);
                en = (r[4:0] < 5'd27);      // about 85 percent
            end
            drive_cycle(en, vld, clr, a, b);
        end
    endtask

    initial begin
        #(TIMEOUT);
        $display("timeout: the run did not finish within %0d time units", TIMEOUT);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        logic [31:0] r;
        int          k;
        rst_i        = 1'b1;
        en_i         = 1'b0;
        valid_i      = 1'b0;
        clear_i      = 1'b0;
        a_i          = '0;
        b_i          = '0;
        shift_i      = '0;
        rnd_mode_i   = RND_TRUNC;
        cur_shift    = '0;
        cur_rnd      = RND_TRUNC;
        lfsr_state   = 32'h3a1a_7f96;
        model_sum    = '0;
        exp_valid    = 1'b0;
        exp_ovf      = 1'b0;
        exp_accum    = '0;
        exp_result   = '0;
        exp_sat      = 1'b0;
        n_checks     = 0;
        mismatch_cnt = 0;
        other_cnt    = 0;
        valid_seen   = 0;
        ovf_seen     = 0;
        sat_seen     = 0;
        for (k = 0; k < 3; k++) begin
            pipe_valid[k] = 1'b0;
            pipe_ovf[k]   = 1'b0;
            pipe_sum[k]   = '0;
        end

        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        // everything cleared, no beat seen yet
        if (valid_o !== 1'b0 || overflow_o !== 1'b0 || sat_o !== 1'b0 ||
            accum_o !== '0 || result_o !== '0) begin
            mismatch_cnt++;
            $display("mismatch at %0t: outputs not cleared after reset", $time);
        end

        cur_shift = 5'd6;
        run_phase(PH_RAND, 1'b0, 1'b0, STYLE_RAND);   // en held high
        idle_gap();

        // clear with valid drops its product, clear alone restarts the sum
        drive_cycle(1'b1, 1'b1, 1'b0, 8'sd3, 8'sd4);
        drive_cycle(1'b1, 1'b1, 1'b0, 8'sd5, -8'sd6);
        drive_cycle(1'b1, 1'b1, 1'b1, 8'sd100, 8'sd100);
        drive_cycle(1'b1, 1'b1, 1'b0, 8'sd2, 8'sd3);
        drive_cycle(1'b1, 1'b0, 1'b1, 8'sd9, 8'sd9);
        drive_cycle(1'b1, 1'b1, 1'b0, -8'sd4, 8'sd5);
        idle_gap();

        run_phase(PH_RAND, 1'b1, 1'b1, STYLE_RAND);   // stalls and clears
        idle_gap();

        // start the overflow runs from zero
        drive_cycle(1'b1, 1'b0, 1'b1, '0, '0);
        run_phase(PH_OVF, 1'b1, 1'b0, STYLE_POS);
        idle_gap();
        run_phase(PH_OVF, 1'b0, 1'b0, STYLE_NEG);
        idle_gap();
        if (ovf_seen == 0) begin
            other_cnt++;
            $display("the overflow phases never wrapped the sum");
        end

        // shift and rounding change only here, pipeline drained of valid beats
        for (k = 0; k < N_REQ; k++) begin
            idle_gap();
            draw_bits(4, r);
            cur_shift = {(k >= 6), r[3:0]};
            cur_rnd   = k[0] ? RND_HALF_UP : RND_TRUNC;
            run_phase(PH_REQ, 1'b1, 1'b1, STYLE_RAND);
        end
        idle_gap();

        if (valid_seen == 0) begin
            other_cnt++;
            $display("no valid result ever left the pipeline");
        end
        if (sat_seen == 0) begin
            other_cnt++;
            $display("no result needed saturation");
        end

        $display("checks %0d, valid results %0d, mismatches %0d, other errors %0d",
                 n_checks, valid_seen, mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
